/* logic/lc3b_pkg.sv */
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	// one-hot {n, z, p}
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_alu_op alu_op;
		logic use_imm;
		logic load_regfile;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		logic is_br;
		logic is_jmp;
		lc3b_word offset;
	} lc3b_control_word;

	localparam lc3b_word pc_reset = 16'h0000;
	localparam lc3b_nzp cc_reset = 3'b010;

	// sign and zero test of a result
	function automatic lc3b_nzp gen_cc(input lc3b_word value);
		if (value[15]) begin
			return 3'b100;
		end else if (value == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

endpackage : lc3b_pkg

/* logic/pipe_if.sv */
`timescale 1ns/1ps

interface de_ex_if import lc3b_pkg::*; ();
	lc3b_word npc;
	lc3b_control_word cw;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_word imm;
	lc3b_reg dr;
	lc3b_reg sr1_reg;
	lc3b_reg sr2_reg;
	logic valid;

	modport src (output npc, cw, sr1, sr2, imm, dr, sr1_reg, sr2_reg, valid);
	modport dst (input npc, cw, sr1, sr2, imm, dr, sr1_reg, sr2_reg, valid);
endinterface : de_ex_if

interface ex_mem_if import lc3b_pkg::*; ();
	lc3b_control_word cw;
	lc3b_word result;
	lc3b_word address;
	lc3b_word wdata;
	lc3b_nzp nzp_cond;
	lc3b_reg dr;
	logic valid;

	modport src (output cw, result, address, wdata, nzp_cond, dr, valid);
	modport dst (input cw, result, address, wdata, nzp_cond, dr, valid);
endinterface : ex_mem_if

interface wb_if import lc3b_pkg::*; ();
	logic ld_reg;
	lc3b_reg dr;
	lc3b_word data;
	lc3b_nzp cc;
	logic stall;

	modport src (output ld_reg, dr, data, cc, stall);
	modport writer (input ld_reg, dr, data, stall);
	modport monitor (input ld_reg, dr, data, cc, stall);
endinterface : wb_if

/* logic/fetch.sv */
`timescale 1ns/1ps

module fetch import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word imem_rdata,
	input logic redirect,
	input lc3b_word target,
	input logic stall,
	output lc3b_word imem_addr,
	output lc3b_word ir,
	output lc3b_word npc,
	output logic valid
);

	lc3b_word pc;
	lc3b_word pc_next;

	assign pc_next = pc + 16'd2;
	assign imem_addr = pc;

	// redirect only arrives when not stalled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= pc_reset;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= 1'b0;
		end else if (!stall) begin
			valid <= !redirect;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ir <= imem_rdata;
			npc <= pc_next;
		end
	end

endmodule : fetch

/* logic/decode.sv */
`timescale 1ns/1ps

module decode import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word ir,
	input lc3b_word npc,
	input logic valid,
	input logic flush,
	wb_if.writer wb,
	de_ex_if.src out
);

	lc3b_opcode opcode;
	lc3b_control_word cw;
	logic supported;
	lc3b_word offset;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word off11;
	lc3b_word imm5;
	lc3b_reg sr1_reg;
	lc3b_reg sr2_reg;
	lc3b_word sr1_val;
	lc3b_word sr2_val;
	lc3b_word regs [8];

	assign opcode = lc3b_opcode'(ir[15:12]);

	// word offsets are shifted left once
	assign off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
	assign off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
	assign off11 = {{4{ir[10]}}, ir[10:0], 1'b0};
	assign imm5 = {{11{ir[4]}}, ir[4:0]};

	always_comb begin
		case (opcode)
			op_ldr, op_str: offset = off6;
			op_br, op_lea: offset = off9;
			default: offset = off11;
		endcase
	end

	always_comb begin
		cw = '0;
		cw.opcode = opcode;
		cw.alu_op = alu_pass;
		cw.offset = offset;
		supported = 1'b1;
		case (opcode)
			op_add, op_and: begin
				cw.alu_op = (opcode == op_add) ? alu_add : alu_and;
				cw.use_imm = ir[5];
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			op_not: begin
				cw.alu_op = alu_not;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			// LEA leaves the condition codes alone
			op_lea: cw.load_regfile = 1'b1;
			op_ldr: begin
				cw.mem_read = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			op_str: cw.mem_write = 1'b1;
			op_br: cw.is_br = 1'b1;
			op_jmp: cw.is_jmp = 1'b1;
			default: supported = 1'b0;
		endcase
	end

	// STR reads its source from the dr field
	assign sr1_reg = ir[8:6];
	assign sr2_reg = (opcode == op_str) ? ir[11:9] : ir[2:0];

	always_ff @(posedge clk) begin
		if (wb.ld_reg) begin
			regs[wb.dr] <= wb.data;
		end
	end

	// write-through from the retiring instruction
	assign sr1_val = (wb.ld_reg && wb.dr == sr1_reg) ? wb.data : regs[sr1_reg];
	assign sr2_val = (wb.ld_reg && wb.dr == sr2_reg) ? wb.data : regs[sr2_reg];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out.valid <= 1'b0;
		end else if (flush) begin
			out.valid <= 1'b0;
		end else if (!wb.stall) begin
			out.valid <= valid && supported;
		end
	end

	always_ff @(posedge clk) begin
		if (!wb.stall) begin
			out.npc <= npc;
			out.cw <= cw;
			out.sr1 <= sr1_val;
			out.sr2 <= sr2_val;
			out.imm <= imm5;
			// nzp mask for BR
			out.dr <= ir[11:9];
			out.sr1_reg <= sr1_reg;
			out.sr2_reg <= sr2_reg;
		end
	end

endmodule : decode

/* logic/execute.sv */
`timescale 1ns/1ps

module execute import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	de_ex_if.dst in,
	wb_if.monitor wb,
	ex_mem_if.src out,
	output logic redirect,
	output lc3b_word target
);

	lc3b_word src_a;
	lc3b_word src_b;
	lc3b_word operand_b;
	lc3b_word base;
	lc3b_word address;
	lc3b_word result;
	logic is_mem;
	logic br_taken;

	// forward from the stage retiring this cycle
	assign src_a = (wb.ld_reg && wb.dr == in.sr1_reg) ? wb.data : in.sr1;
	assign src_b = (wb.ld_reg && wb.dr == in.sr2_reg) ? wb.data : in.sr2;

	assign operand_b = in.cw.use_imm ? in.imm : src_b;

	assign is_mem = in.cw.mem_read || in.cw.mem_write;
	assign base = is_mem ? src_a : in.npc;
	assign address = base + in.cw.offset;

	always_comb begin
		result = address;
		case (in.cw.alu_op)
			alu_add: result = src_a + operand_b;
			alu_and: result = src_a & operand_b;
			alu_not: result = ~src_a;
			alu_pass: result = address;
		endcase
	end

	// dr holds the nzp mask for BR
	assign br_taken = in.cw.is_br && |(in.dr & wb.cc);

	assign target = in.cw.is_jmp ? src_a : address;
	assign redirect = in.valid && !wb.stall && (br_taken || in.cw.is_jmp);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out.valid <= 1'b0;
		end else if (!wb.stall) begin
			out.valid <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!wb.stall) begin
			out.cw <= in.cw;
			out.result <= result;
			out.address <= address;
			out.wdata <= src_b;
			out.nzp_cond <= gen_cc(result);
			out.dr <= in.dr;
		end
	end

endmodule : execute

/* logic/mem_wb.sv */
`timescale 1ns/1ps

module mem_wb import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word dmem_rdata,
	input logic dmem_resp,
	ex_mem_if.dst in,
	wb_if.src wb,
	output lc3b_word dmem_addr,
	output lc3b_word dmem_wdata,
	output logic dmem_read,
	output logic dmem_write
);

	lc3b_nzp cc_q;
	lc3b_nzp new_cc;
	logic done;

	// request held until the response cycle
	assign dmem_read = in.valid && in.cw.mem_read;
	assign dmem_write = in.valid && in.cw.mem_write;
	assign dmem_addr = in.address;
	assign dmem_wdata = in.wdata;

	assign wb.stall = (dmem_read || dmem_write) && !dmem_resp;
	assign done = in.valid && !wb.stall;

	assign wb.ld_reg = done && in.cw.load_regfile;
	assign wb.dr = in.dr;
	assign wb.data = in.cw.mem_read ? dmem_rdata : in.result;

	// load data only known here, ALU results were tested in execute
	assign new_cc = in.cw.mem_read ? gen_cc(dmem_rdata) : in.nzp_cond;
	assign wb.cc = (done && in.cw.load_cc) ? new_cc : cc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cc_q <= cc_reset;
		end else begin
			cc_q <= wb.cc;
		end
	end

endmodule : mem_wb

/* logic/lc3b_pipe.sv */
`timescale 1ns/1ps

module lc3b_pipe import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	output lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_word dmem_wdata,
	input lc3b_word dmem_rdata,
	input logic dmem_resp
);

	lc3b_word fd_ir;
	lc3b_word fd_npc;
	logic fd_valid;
	logic redirect;
	lc3b_word target;

	de_ex_if de_ex ();
	ex_mem_if ex_mem ();
	wb_if wb ();

	fetch fetch_i (
		.clk,
		.arst_n,
		.imem_rdata,
		.redirect,
		.target,
		.stall(wb.stall),
		.imem_addr,
		.ir(fd_ir),
		.npc(fd_npc),
		.valid(fd_valid)
	);

	// redirect also squashes the entry behind the branch
	decode decode_i (
		.clk,
		.arst_n,
		.ir(fd_ir),
		.npc(fd_npc),
		.valid(fd_valid),
		.flush(redirect),
		.wb(wb.writer),
		.out(de_ex.src)
	);

	execute execute_i (
		.clk,
		.arst_n,
		.in(de_ex.dst),
		.wb(wb.monitor),
		.out(ex_mem.src),
		.redirect,
		.target
	);

	mem_wb mem_wb_i (
		.clk,
		.arst_n,
		.dmem_rdata,
		.dmem_resp,
		.in(ex_mem.dst),
		.wb(wb.src),
		.dmem_addr,
		.dmem_wdata,
		.dmem_read,
		.dmem_write
	);

endmodule : lc3b_pipe

/* dv/pipe_assert.sv */
`timescale 1ns/1ps

module pipe_assert import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic dmem_read,
	input logic dmem_write,
	input lc3b_word dmem_addr,
	input lc3b_word dmem_wdata,
	input logic dmem_resp,
	input lc3b_word imem_addr
);

	int fails;

	initial begin
		fails = 0;
	end

	strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(dmem_read && dmem_write))
		else begin
			$error("dmem_read and dmem_write are high together");
			fails++;
		end

	// a waiting request keeps its strobe and address
	request_held: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_read || dmem_write) && !dmem_resp |=>
		$stable(dmem_addr) && $stable(dmem_read) && $stable(dmem_write))
		else begin
			$error("data request changed before its response");
			fails++;
		end

	wdata_held: assert property (@(posedge clk) disable iff (!arst_n)
		dmem_write && !dmem_resp |=> $stable(dmem_wdata))
		else begin
			$error("store data changed before its response");
			fails++;
		end

	// also the first edge after release
	reset_quiet: assert property (@(posedge clk)
		!arst_n || $rose(arst_n) |-> !dmem_read && !dmem_write && imem_addr == pc_reset)
		else begin
			$error("strobes or fetch address wrong during or right after reset");
			fails++;
		end

endmodule : pipe_assert

bind lc3b_pipe pipe_assert pipe_assert_i (.*);

/* dv/pipe_checker.sv */
`timescale 1ns/1ps

module pipe_checker import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input int case_id,
	input int exp_count,
	input lc3b_word exp_addr [8],
	input lc3b_word exp_data [8],
	input logic dmem_write,
	input logic dmem_resp,
	input lc3b_word dmem_addr,
	input lc3b_word dmem_wdata,
	output int seen,
	output int errors
);

	initial begin
		errors = 0;
	end

	// a store completes on the edge where its response is high
	always @(posedge clk) begin
		if (!arst_n) begin
			seen = 0;
		end else if (dmem_write && dmem_resp) begin
			if (seen >= exp_count) begin
				$display("case_%0d: store to %h with data %h is beyond the %0d expected stores",
					case_id, dmem_addr, dmem_wdata, exp_count);
				errors++;
			end else begin
				if (dmem_addr !== exp_addr[seen]) begin
					$display("[ERROR] case_%0d store %0d address: expected %h, actual %h",
						case_id, seen, exp_addr[seen], dmem_addr);
					errors++;
				end
				if (dmem_wdata !== exp_data[seen]) begin
					$display("[ERROR] case_%0d store %0d data: expected %h, actual %h",
						case_id, seen, exp_data[seen], dmem_wdata);
					errors++;
				end
			end
			seen++;
		end
	end

endmodule : pipe_checker

/* dv/tb_lc3b_pipe.sv */
`timescale 1ns/1ps

module tb_lc3b_pipe import lc3b_pkg::*; ();

	logic clk;
	logic arst_n;
	lc3b_word imem_addr;
	lc3b_word imem_rdata;
	lc3b_word dmem_addr;
	logic dmem_read;
	logic dmem_write;
	lc3b_word dmem_wdata;
	lc3b_word dmem_rdata;
	logic dmem_resp;

	lc3b_word cases [320];
	lc3b_word imem [32];
	lc3b_word dmem [256];
	lc3b_word exp_addr [8];
	lc3b_word exp_data [8];
	int exp_count;
	int case_id;
	int seen;
	int errors;
	int timeouts;
	logic [31:0] lfsr;
	logic waiting;
	logic [1:0] delay;

	lc3b_pipe lc3b_pipe_i (.*);

	pipe_checker checker_i (.*);

	// instruction port answers in the same cycle
	assign imem_rdata = imem[imem_addr[5:1]];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'hA300_0000;
		end
		return out;
	endfunction

	// data port with 0 to 3 wait cycles
	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dmem_resp <= 1'b0;
			waiting = 1'b0;
		end else if (dmem_resp) begin
			dmem_resp <= 1'b0;
		end else if (dmem_read || dmem_write) begin
			if (!waiting) begin
				delay[1] = lfsr_bit();
				delay[0] = lfsr_bit();
				waiting = 1'b1;
			end
			if (delay == 2'd0) begin
				waiting = 1'b0;
				if (dmem_write) begin
					dmem[dmem_addr[8:1]] = dmem_wdata;
				end else begin
					dmem_rdata <= dmem[dmem_addr[8:1]];
				end
				dmem_resp <= 1'b1;
			end else begin
				delay = delay - 2'd1;
			end
		end
	end

	task automatic load_case(input int base);
		case_id = cases[base];
		for (int i = 0; i < 32; i++) begin
			imem[i] = (i < cases[base + 1]) ? cases[base + 2 + i] : 16'h0000;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 16'(i * 16'h0107) ^ 16'hA5C3;
		end
		for (int i = 0; i < 8; i++) begin
			dmem[i] = cases[base + 8'h22 + i];
		end
		exp_count = cases[base + 8'h2A];
		for (int i = 0; i < 8; i++) begin
			exp_addr[i] = cases[base + 8'h2B + 2 * i];
			exp_data[i] = cases[base + 8'h2C + 2 * i];
		end
	endtask

	task automatic run_case(input int base);
		int limit;
		int cycles;
		arst_n = 1'b0;
		load_case(base);
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		limit = (cases[base + 1] + 4 * exp_count) * 8;
		cycles = 0;
		while (seen < exp_count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (seen < exp_count) begin
			$display("case_%0d did not finish: %0d of %0d stores within %0d cycles",
				case_id, seen, exp_count, limit);
			timeouts++;
		end else begin
			// room for any store that should not come
			repeat (16) @(negedge clk);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		dmem_rdata = '0;
		dmem_resp = 1'b0;
		exp_count = 0;
		case_id = 0;
		timeouts = 0;
		lfsr = 32'h718d_7728;
		for (int i = 0; i < 8; i++) begin
			exp_addr[i] = '0;
			exp_data[i] = '0;
		end
		$readmemh("dv/pipe_cases.txt", cases);
		@(negedge clk);
		// an unfinished case ends the run
		for (int k = 0; k < cases[0] && timeouts == 0; k++) begin
			run_case(64 + 64 * k);
		end
		$display("store check errors: %0d, assertion failures: %0d, unfinished cases: %0d",
			errors, lc3b_pipe_i.pipe_assert_i.fails, timeouts);
		if (errors == 0 && timeouts == 0 && lc3b_pipe_i.pipe_assert_i.fails == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule : tb_lc3b_pipe

/* project.f */
logic/lc3b_pkg.sv
logic/pipe_if.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_wb.sv
logic/lc3b_pipe.sv
dv/pipe_assert.sv
dv/pipe_checker.sv
dv/tb_lc3b_pipe.sv

/* dv/pipe_cases.txt */
// record of 0x40 words per case: name index, program length, program[32] at +0x02,
// data[8] at +0x22, store count at +0x2A, (address, data) store pairs from +0x2B
@0 0004
// ALU chain through forwarding and write-through
@40 0001 000B
@42 5020 1225 1441 56BC 98FF 1B02 7400 7601 7802 7A03 0FFF
@62 1111 2222 3333 4444 5555 6666 7777 8888
@6A 0004 0000 000A 0002 0008 0004 FFF7 0006 0001
// load then dependent use
@80 0002 000A
@82 5020 6200 1463 7404 6601 18C1 7805 6A04 7A06 0FFF
@A2 1234 0FF0 0102 0304 0506 0708 090A 0B0C
@AA 0003 0008 1237 000A 2224 000C 1237
// BR masks, markers store to 000E
@C0 0003 0013
@C2 5020 0402 7007 7007 123F 0802 7007 7007 1423 0202 7007 7007 0C02 7400 7201 5642
@D2 0802 7602 0FFF
@E2 0A0A 0B0B 0C0C 0D0D 0E0E 0F0F 1010 1111
@EA 0003 0000 0003 0002 FFFF 0004 0003
// LEA and JMP, then stores back to back
@100 0004 000C
@102 5020 E203 7200 C040 7007 E5FE 7401 16A1 7602 7603 7404 0FFF
@122 AAAA BBBB CCCC DDDD EEEE FFFF 0123 4567
@12A 0005 0000 000A 0002 0008 0004 0009 0006 0009 0008 0008
